// ==== Makefile ====
# Verilator build and run of the UDP echo testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, check the result"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module udp_echo_tb -o udp_echo_sim
	./obj_dir/udp_echo_sim > sim.log 2>&1 || true
	@cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
hdl/udp_echo_pkg.sv
hdl/udp_payload_if.sv
hdl/udp_echo_dispatch.sv
hdl/udp_payload_fifo.sv
hdl/udp_led_capture.sv
hdl/udp_echo_top.sv
test/udp_echo_tb.sv

// ==== hdl/udp_echo_dispatch.sv ====
/*
 * Port filter and reply header builder for the echo core.
 * Header handshake is combinational: a matching header passes straight through.
 * Payload of a non-matching datagram is accepted and dropped.
 * Each datagram must carry at least one payload byte ending with last.
 */
`default_nettype none

module udp_echo_dispatch import udp_echo_pkg::*; #(
    parameter ip_addr_t  LOCAL_IP  = DEFAULT_LOCAL_IP,
    parameter udp_port_t ECHO_PORT = DEFAULT_ECHO_PORT
) (
    input  logic          clk,
    input  logic          rst,

    input  logic          rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  udp_rx_hdr_t   rx_hdr,

    input  byte_t         rx_payload_data,
    input  logic          rx_payload_valid,
    input  logic          rx_payload_last,
    input  logic          rx_payload_user,
    output logic          rx_payload_ready,

    output logic          tx_hdr_valid,
    input  logic          tx_hdr_ready,
    output udp_tx_hdr_t   tx_hdr,

    udp_payload_if.source fifo_in
);

    typedef enum logic [1:0] {IDLE, FORWARD, DISCARD} state_t;

    state_t state;
    state_t state_next;
    logic   match;
    logic   payload_done;

    assign match = rx_hdr.dest_port == ECHO_PORT;

    // Header side, only live between datagrams
    assign tx_hdr_valid = (state == IDLE) && rx_hdr_valid && match;
    assign rx_hdr_ready = (state == IDLE) && rx_hdr_valid && (!match || tx_hdr_ready);

    // Reply goes back where the request came from
    assign tx_hdr.source_ip   = LOCAL_IP;
    assign tx_hdr.dest_ip     = rx_hdr.source_ip;
    assign tx_hdr.ttl         = ECHO_TTL;
    assign tx_hdr.source_port = rx_hdr.dest_port;
    assign tx_hdr.dest_port   = rx_hdr.source_port;
    assign tx_hdr.length      = rx_hdr.length;
    assign tx_hdr.checksum    = '0;

    // Payload steering
    assign fifo_in.data  = rx_payload_data;
    assign fifo_in.last  = rx_payload_last;
    assign fifo_in.user  = rx_payload_user;
    assign fifo_in.valid = (state == FORWARD) && rx_payload_valid;

    assign rx_payload_ready = (state == FORWARD) ? fifo_in.ready : (state == DISCARD);

    assign payload_done = rx_payload_valid && rx_payload_ready && rx_payload_last;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (rx_hdr_valid && rx_hdr_ready) begin
                    state_next = match ? FORWARD : DISCARD;
                end
            end
            FORWARD, DISCARD: begin
                if (payload_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // A new header must wait until the current payload has ended
    assert property (@(posedge clk) disable iff (rst)
        rx_hdr_valid && rx_hdr_ready |=> !rx_hdr_ready);

    // Dropped payload never reaches the FIFO
    assert property (@(posedge clk) disable iff (rst)
        rx_hdr_valid && rx_hdr_ready && !match |=> rx_payload_ready && !fifo_in.valid);

endmodule

`default_nettype wire

// ==== hdl/udp_echo_pkg.sv ====
/*
 * Shared types and constants of the UDP echo core.
 * Header structs are packed in field order, most significant field first.
 * The reply checksum is always zero, so no checksum logic is needed downstream.
 */
`default_nettype none

package udp_echo_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Header as delivered by the receive side
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_rx_hdr_t;

    // Header handed to the transmit side
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        byte_t     ttl;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;
        udp_len_t  checksum;
    } udp_tx_hdr_t;

    localparam byte_t     ECHO_TTL          = 8'd64;
    localparam ip_addr_t  DEFAULT_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

endpackage

`default_nettype wire

// ==== hdl/udp_echo_top.sv ====
/*
 * UDP echo core with plain header and payload ports.
 * Datagrams to ECHO_PORT are answered from LOCAL_IP; others are dropped.
 * FIFO_DEPTH sets payload buffering and must be a power of two, at least 4.
 * Several replies may be in flight; headers can run ahead of their payload.
 */
`default_nettype none

module udp_echo_top import udp_echo_pkg::*; #(
    parameter ip_addr_t  LOCAL_IP   = DEFAULT_LOCAL_IP,
    parameter udp_port_t ECHO_PORT  = DEFAULT_ECHO_PORT,
    parameter int        FIFO_DEPTH = 64
) (
    input  logic      clk,
    input  logic      rst,

    // Receive header
    input  logic      rx_hdr_valid,
    output logic      rx_hdr_ready,
    input  ip_addr_t  rx_source_ip,
    input  ip_addr_t  rx_dest_ip,
    input  udp_port_t rx_source_port,
    input  udp_port_t rx_dest_port,
    input  udp_len_t  rx_length,

    // Receive payload
    input  byte_t     rx_payload_data,
    input  logic      rx_payload_valid,
    input  logic      rx_payload_last,
    input  logic      rx_payload_user,
    output logic      rx_payload_ready,

    // Reply header
    output logic      tx_hdr_valid,
    input  logic      tx_hdr_ready,
    output ip_addr_t  tx_source_ip,
    output ip_addr_t  tx_dest_ip,
    output byte_t     tx_ttl,
    output udp_port_t tx_source_port,
    output udp_port_t tx_dest_port,
    output udp_len_t  tx_length,
    output udp_len_t  tx_checksum,

    // Reply payload
    output byte_t     tx_payload_data,
    output logic      tx_payload_valid,
    output logic      tx_payload_last,
    output logic      tx_payload_user,
    input  logic      tx_payload_ready,

    output byte_t     led
);

    udp_rx_hdr_t rx_hdr;
    udp_tx_hdr_t tx_hdr;

    udp_payload_if fifo_in_if ();
    udp_payload_if fifo_out_if ();

    assign rx_hdr = '{rx_source_ip, rx_dest_ip, rx_source_port, rx_dest_port, rx_length};

    assign {tx_source_ip, tx_dest_ip, tx_ttl, tx_source_port,
            tx_dest_port, tx_length, tx_checksum} = tx_hdr;

    assign tx_payload_data   = fifo_out_if.data;
    assign tx_payload_valid  = fifo_out_if.valid;
    assign tx_payload_last   = fifo_out_if.last;
    assign tx_payload_user   = fifo_out_if.user;
    assign fifo_out_if.ready = tx_payload_ready;

    udp_echo_dispatch #(
        .LOCAL_IP  (LOCAL_IP),
        .ECHO_PORT (ECHO_PORT)
    ) dispatch_i (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_hdr           (rx_hdr),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_hdr           (tx_hdr),
        .fifo_in          (fifo_in_if.source)
    );

    udp_payload_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk (clk),
        .rst (rst),
        .wr  (fifo_in_if.sink),
        .rd  (fifo_out_if.source)
    );

    udp_led_capture led_i (
        .clk (clk),
        .rst (rst),
        .mon (fifo_out_if.sink),
        .led (led)
    );

endmodule

`default_nettype wire

// ==== hdl/udp_led_capture.sv ====
/*
 * Shows the first byte of each outgoing datagram on the LEDs.
 * Watches the output stream only and never drives its ready.
 * LEDs update on the edge that transfers the first beat.
 */
`default_nettype none

module udp_led_capture import udp_echo_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    udp_payload_if.sink mon,
    output byte_t       led
);

    logic in_frame;
    logic xfer;

    assign xfer = mon.valid && mon.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            led      <= '0;
            in_frame <= 1'b0;
        end else if (xfer) begin
            if (!in_frame) begin
                led <= mon.data;
            end
            // Single-byte datagrams leave the flag clear
            in_frame <= !mon.last;
        end
    end

    // Stalled output beat holds its byte
    assert property (@(posedge clk) disable iff (rst)
        mon.valid && !mon.ready |=> mon.valid && $stable(mon.data));

endmodule

`default_nettype wire

// ==== hdl/udp_payload_fifo.sv ====
/*
 * Synchronous FIFO for payload beats with their last and user flags.
 * DEPTH must be a power of two, at least 4.
 * Output is read straight from the array, so a beat written on one edge
 * shows at the output from the next cycle. No almost-full or count outputs.
 */
`default_nettype none

module udp_payload_fifo import udp_echo_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst,
    udp_payload_if.sink   wr,
    udp_payload_if.source rd
);

    localparam int AW = $clog2(DEPTH);

    // Entry layout: {user, last, data}
    typedef logic [$bits(byte_t)+1:0] entry_t;

    entry_t        mem [DEPTH];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;
    logic          do_write;
    logic          do_read;

    // Extra pointer bit tells full from empty
    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr.ready = !full;
    assign rd.valid = !empty;

    assign do_write = wr.valid && wr.ready;
    assign do_read  = rd.valid && rd.ready;

    assign {rd.user, rd.last, rd.data} = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= {wr.user, wr.last, wr.data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Occupancy never exceeds the array, so no write lands on a full FIFO
    assert property (@(posedge clk) disable iff (rst)
        (AW+1)'(wr_ptr - rd_ptr) <= DEPTH);

endmodule

`default_nettype wire

// ==== hdl/udp_payload_if.sv ====
/*
 * Byte stream with valid/ready handshake, plus last and user flags.
 * A beat moves on a clock edge with valid and ready both high.
 * Data, last and user must hold while valid waits for ready.
 */
`default_nettype none

interface udp_payload_if import udp_echo_pkg::*; ();

    byte_t data;
    logic  valid;
    logic  ready;
    logic  last;
    logic  user;

    modport source (
        output data,
        output valid,
        output last,
        output user,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  user,
        output ready
    );

endinterface

`default_nettype wire

// ==== test/udp_echo_tb.sv ====
/*
 * Testbench for the UDP echo core: random datagrams under random back-pressure.
 * Inputs change on the falling edge and outputs are sampled 1 ns later.
 * Expected replies are queued before each request is presented.
 */
`default_nettype none

module udp_echo_tb import udp_echo_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam ip_addr_t  MODEL_LOCAL_IP  = 32'hc0a8_0180;
    localparam udp_port_t MODEL_ECHO_PORT = 16'd1234;
    localparam int        NUM_DATAGRAMS   = 40;
    localparam int        WAIT_LIMIT      = 1000;

    logic      clk;
    logic      rst;
    logic      rx_hdr_valid;
    logic      rx_hdr_ready;
    ip_addr_t  rx_source_ip;
    ip_addr_t  rx_dest_ip;
    udp_port_t rx_source_port;
    udp_port_t rx_dest_port;
    udp_len_t  rx_length;
    byte_t     rx_payload_data;
    logic      rx_payload_valid;
    logic      rx_payload_last;
    logic      rx_payload_user;
    logic      rx_payload_ready;
    logic      tx_hdr_valid;
    logic      tx_hdr_ready;
    ip_addr_t  tx_source_ip;
    ip_addr_t  tx_dest_ip;
    byte_t     tx_ttl;
    udp_port_t tx_source_port;
    udp_port_t tx_dest_port;
    udp_len_t  tx_length;
    udp_len_t  tx_checksum;
    byte_t     tx_payload_data;
    logic      tx_payload_valid;
    logic      tx_payload_last;
    logic      tx_payload_user;
    logic      tx_payload_ready;
    byte_t     led;

    // Model state; beats are stored as {user, last, data}
    udp_tx_hdr_t exp_hdr_q[$];
    logic [9:0]  exp_beat_q[$];
    integer      seed = 32'h28483f37;
    logic        in_frame = 1'b0;
    logic        led_pending = 1'b0;
    byte_t       led_expect = 8'd0;

    udp_echo_top #(
        .LOCAL_IP   (MODEL_LOCAL_IP),
        .ECHO_PORT  (MODEL_ECHO_PORT),
        .FIFO_DEPTH (16)
    ) dut_i (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_source_ip     (rx_source_ip),
        .rx_dest_ip       (rx_dest_ip),
        .rx_source_port   (rx_source_port),
        .rx_dest_port     (rx_dest_port),
        .rx_length        (rx_length),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .rx_payload_ready (rx_payload_ready),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_source_ip     (tx_source_ip),
        .tx_dest_ip       (tx_dest_ip),
        .tx_ttl           (tx_ttl),
        .tx_source_port   (tx_source_port),
        .tx_dest_port     (tx_dest_port),
        .tx_length        (tx_length),
        .tx_checksum      (tx_checksum),
        .tx_payload_data  (tx_payload_data),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_last  (tx_payload_last),
        .tx_payload_user  (tx_payload_user),
        .tx_payload_ready (tx_payload_ready),
        .led              (led)
    );

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED: %s expected %0h actual %0h",
                                     name, expected, actual));
        end
    endtask

    // Entered and left just after a falling edge
    task automatic present_header(input udp_rx_hdr_t req, input logic matched);
        int   waited;
        logic done;
        waited = 0;
        done = 1'b0;
        rx_hdr_valid = 1'b1;
        {rx_source_ip, rx_dest_ip, rx_source_port, rx_dest_port, rx_length} = req;
        while (!done) begin
            #1;
            // Reply header is combinational from the request
            check_value("reply header valid", 32'(matched), 32'(tx_hdr_valid));
            if (rx_hdr_ready) begin
                done = 1'b1;
            end else if (waited == WAIT_LIMIT) begin
                report_failure("Timeout: receive header was never accepted");
            end else begin
                waited++;
            end
            @(negedge clk);
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic present_beat(input logic [9:0] beat);
        int          waited;
        logic        done;
        logic [31:0] r;
        waited = 0;
        done = 1'b0;
        {rx_payload_user, rx_payload_last, rx_payload_data} = beat;
        while (!done) begin
            r = next_random();
            // Idle gaps only before valid rises
            if (!rx_payload_valid) begin
                rx_payload_valid = r[1:0] != 2'b00;
            end
            #1;
            if (rx_payload_valid && rx_payload_ready) begin
                done = 1'b1;
            end else if (waited == WAIT_LIMIT) begin
                report_failure("Timeout: payload byte was never accepted");
            end else begin
                waited++;
            end
            @(negedge clk);
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic send_datagram();
        logic [31:0] r;
        int          len;
        logic        matched;
        udp_rx_hdr_t req;
        udp_tx_hdr_t rep;
        logic [9:0]  beats[$];
        r = next_random();
        len = int'(r % 32'd20) + 1;
        req.source_ip = next_random();
        req.dest_ip = MODEL_LOCAL_IP;
        r = next_random();
        req.source_port = r[15:0];
        req.dest_port = r[0] ? MODEL_ECHO_PORT : r[31:16];
        req.length = 16'(len + 8);
        matched = req.dest_port == MODEL_ECHO_PORT;
        for (int i = 0; i < len; i++) begin
            r = next_random();
            beats.push_back({r[9], i == len - 1, r[7:0]});
        end
        if (matched) begin
            rep.source_ip = MODEL_LOCAL_IP;
            rep.dest_ip = req.source_ip;
            rep.ttl = ECHO_TTL;
            rep.source_port = req.dest_port;
            rep.dest_port = req.source_port;
            rep.length = req.length;
            rep.checksum = 16'd0;
            exp_hdr_q.push_back(rep);
            foreach (beats[i]) begin
                exp_beat_q.push_back(beats[i]);
            end
        end
        present_header(req, matched);
        foreach (beats[i]) begin
            present_beat(beats[i]);
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("Timeout: echoed payload did not drain from the DUT");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Random back-pressure on both reply channels
    initial begin
        logic [31:0] r;
        forever begin
            @(negedge clk);
            if (!rst) begin
                r = next_random();
                tx_hdr_ready = r[0];
                tx_payload_ready = r[1];
            end
        end
    end

    // Output monitor, sampled before each rising edge
    initial begin
        udp_tx_hdr_t exp_hdr;
        logic [9:0]  exp_beat;
        forever begin
            @(negedge clk);
            #1;
            if (!rst) begin
                if (led_pending) begin
                    check_value("led first byte", 32'(led_expect), 32'(led));
                    led_pending = 1'b0;
                end
                if (tx_hdr_valid && tx_hdr_ready) begin
                    if (exp_hdr_q.size() == 0) begin
                        report_failure("Reply header sent with no matching request");
                    end else begin
                        exp_hdr = exp_hdr_q.pop_front();
                        check_value("reply source ip", exp_hdr.source_ip, tx_source_ip);
                        check_value("reply dest ip", exp_hdr.dest_ip, tx_dest_ip);
                        check_value("reply ttl", 32'(exp_hdr.ttl), 32'(tx_ttl));
                        check_value("reply source port", 32'(exp_hdr.source_port),
                                    32'(tx_source_port));
                        check_value("reply dest port", 32'(exp_hdr.dest_port),
                                    32'(tx_dest_port));
                        check_value("reply length", 32'(exp_hdr.length), 32'(tx_length));
                        check_value("reply checksum", 32'(exp_hdr.checksum), 32'(tx_checksum));
                    end
                end
                if (tx_payload_valid && tx_payload_ready) begin
                    if (exp_beat_q.size() == 0) begin
                        report_failure("Payload byte sent that no request asked for");
                    end else begin
                        exp_beat = exp_beat_q.pop_front();
                        check_value("payload beat", 32'(exp_beat),
                                    32'({tx_payload_user, tx_payload_last, tx_payload_data}));
                        if (!in_frame) begin
                            led_pending = 1'b1;
                            led_expect = exp_beat[7:0];
                        end
                        in_frame = !exp_beat[8];
                    end
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_source_ip = '0;
        rx_dest_ip = '0;
        rx_source_port = '0;
        rx_dest_port = '0;
        rx_length = '0;
        rx_payload_data = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last = 1'b0;
        rx_payload_user = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_payload_ready = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        #1;
        check_value("idle reply header valid", 32'd0, 32'(tx_hdr_valid));
        check_value("idle payload valid", 32'd0, 32'(tx_payload_valid));
        check_value("idle led", 32'd0, 32'(led));
        check_value("idle header ready", 32'd0, 32'(rx_hdr_ready));
        check_value("idle payload ready", 32'd0, 32'(rx_payload_ready));
        @(negedge clk);
        for (int n = 0; n < NUM_DATAGRAMS; n++) begin
            send_datagram();
        end
        wait_for_drain();
        // One more sample point for the last LED update
        @(negedge clk);
        #2;
        if (exp_hdr_q.size() == 0 && exp_beat_q.size() == 0 && !led_pending) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("Model queues not empty at the end of the run");
        end
    end

endmodule

`default_nettype wire
